// File: Makefile
TOP := irq_subsystem_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f irq_bus.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/irq_subsystem_tb.sv
module irq_subsystem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] IRQ_BASE    = 32'h0000_1000;
	localparam logic [31:0] TIMER_BASE  = 32'h0000_2000;
	localparam int          COUNT_WIDTH = 16;
	localparam int          RESET_CYCLES = 16;
	localparam logic [31:0] SEED = 32'hc199cc26;
	localparam string       TRACE_FILE = "dv/irq_trace.txt";

	typedef logic [8*24-1:0] name_t;

	logic              clk;
	logic              rst;
	irq_pkg::bus_req_t bus_in;
	irq_pkg::bus_rsp_t bus_out;
	logic [14:0]       ext_irq;
	logic              has_req;
	logic              bus_err;

	// Trace columns, one entry per operation
	byte         op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [3:0]  mask_q[$];
	logic [31:0] exp_q[$];
	name_t       name_q[$];

	int          errors;
	int          checks;
	int          cycle_count;
	int          cycle_limit;
	logic        limit_ready;
	logic [31:0] rng_state;

	tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .rst(rst));

	irq_subsystem #(
		.IRQ_BASE   (IRQ_BASE),
		.TIMER_BASE (TIMER_BASE),
		.COUNT_WIDTH(COUNT_WIDTH)
	) UUT (
		.clk    (clk),
		.rst    (rst),
		.bus_in (bus_in),
		.bus_out(bus_out),
		.ext_irq(ext_irq),
		.has_req(has_req),
		.bus_err(bus_err)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Neither slave region matches the bits above the 256 byte window
	function automatic logic is_unmapped(input logic [31:0] addr);
		return (addr >> irq_pkg::REGION_BITS) != (IRQ_BASE >> irq_pkg::REGION_BITS) &&
			(addr >> irq_pkg::REGION_BITS) != (TIMER_BASE >> irq_pkg::REGION_BITS);
	endfunction

	function automatic int compute_limit();
		int total;
		total = RESET_CYCLES + 8;
		foreach (op_q[i]) begin
			case (op_q[i])
				"W", "R": total += 4;
				"I":      total += 1;
				"N":      total += 3;
				"H":      total += int'(data_q[i]) + 8;
				default:  total += 4;
			endcase
			// Room for the random idle gap after each op
			total += 3;
		end
		return total;
	endfunction

	task automatic load_trace(output logic ok);
		int    fd;
		int    n;
		string line;
		byte   op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  mask;
		logic [31:0] exp_val;
		name_t name;
		ok = 1'b1;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			ok = 1'b0;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%c %h %h %h %h %s", op, addr, data, mask, exp_val, name);
				if (n != 6) begin
					$display("Trace line could not be parsed: %0s", line);
					ok = 1'b0;
				end else begin
					op_q.push_back(op);
					addr_q.push_back(addr);
					data_q.push_back(data);
					mask_q.push_back(mask);
					exp_q.push_back(exp_val);
					name_q.push_back(name);
				end
			end
			$fclose(fd);
			if (op_q.size() == 0)
				ok = 1'b0;
		end
	endtask

	task automatic check_rsp(input name_t name, input irq_pkg::bus_rsp_t exp_rsp,
		input irq_pkg::bus_rsp_t act_rsp);
		checks++;
		if (act_rsp !== exp_rsp) begin
			errors++;
			$display("Mismatch %0s: expected rdata %h fc %b, actual rdata %h fc %b",
				name, exp_rsp.rdata, exp_rsp.fc, act_rsp.rdata, act_rsp.fc);
		end
	endtask

	task automatic check_level(input name_t name, input string what, input logic exp_lvl,
		input logic act_lvl);
		checks++;
		if (act_lvl !== exp_lvl) begin
			errors++;
			$display("Mismatch %0s %0s: expected %b, actual %b", name, what, exp_lvl, act_lvl);
		end
	endtask

	// Read completes in the drive cycle, write one cycle later
	task automatic bus_access(input logic is_wr, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] mask, input logic [31:0] exp_data,
		input name_t name);
		irq_pkg::bus_rsp_t exp_rsp;
		logic exp_err;
		exp_rsp.rdata = exp_data;
		exp_rsp.fc = 1'b1;
		exp_err = is_unmapped(addr);
		@(posedge clk);
		#1;
		bus_in.addr = addr;
		bus_in.wdata = data;
		bus_in.mask = mask;
		bus_in.rd = !is_wr;
		bus_in.wr = is_wr;
		@(negedge clk);
		if (is_wr) begin
			check_level(name, "early fc", 1'b0, bus_out.fc);
			@(negedge clk);
		end
		check_rsp(name, exp_rsp, bus_out);
		check_level(name, "bus_err", exp_err, bus_err);
		@(posedge clk);
		#1;
		bus_in.rd = 1'b0;
		bus_in.wr = 1'b0;
	endtask

	task automatic pulse_irq(input logic [31:0] lines);
		@(posedge clk);
		#1 ext_irq = lines[14:0];
		@(posedge clk);
		#1 ext_irq = '0;
	endtask

	task automatic wait_has_req(input int limit, input logic exp_lvl, input name_t name);
		int waited;
		waited = 0;
		@(negedge clk);
		while (has_req !== exp_lvl && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		checks++;
		if (has_req !== exp_lvl) begin
			errors++;
			$display("%0s: has_req did not reach %b within %0d cycles", name, exp_lvl, limit);
		end
	endtask

	task automatic check_idle_level(input logic [31:0] sel, input logic exp_lvl,
		input name_t name);
		@(posedge clk);
		@(negedge clk);
		if (sel == 0)
			check_level(name, "has_req", exp_lvl, has_req);
		else
			check_level(name, "bus_err", exp_lvl, bus_err);
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (limit_ready && cycle_count >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic trace_ok;
		bus_in = '0;
		ext_irq = '0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		cycle_limit = 0;
		limit_ready = 1'b0;
		rng_state = SEED;
		load_trace(trace_ok);
		if (!trace_ok) begin
			$display("Could not read the trace file %0s", TRACE_FILE);
			$display("TEST FAILED");
		end else begin
			cycle_limit = compute_limit();
			limit_ready = 1'b1;
			wait (rst === 1'b0);
			foreach (op_q[i]) begin
				case (op_q[i])
					"W": bus_access(1'b1, addr_q[i], data_q[i], mask_q[i], exp_q[i], name_q[i]);
					"R": bus_access(1'b0, addr_q[i], data_q[i], mask_q[i], exp_q[i], name_q[i]);
					"I": pulse_irq(data_q[i]);
					"H": wait_has_req(int'(data_q[i]) + 8, exp_q[i][0], name_q[i]);
					"N": check_idle_level(addr_q[i], exp_q[i][0], name_q[i]);
					default: begin
						errors++;
						$display("Unknown trace operation in %0s", name_q[i]);
					end
				endcase
				rng_state = next_random(rng_state);
				repeat (rng_state[1:0]) @(posedge clk);
			end
			$display("Checks %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: dv/irq_trace.txt
# op addr data mask expected name, numbers in hex
# W write, R read, I pulse ext_irq, H wait for has_req (data = timer compare), N level (addr 0 has_req, 1 bus_err)
R 00001000 00000000 f 00000000 rst_pending
R 00001004 00000000 f 00000000 rst_enable
R 00002000 00000000 f 00000000 rst_tmr_ctrl
R 00002004 00000000 f 00000000 rst_tmr_compare
R 00002008 00000000 f 00000000 rst_tmr_count
R 00001008 00000000 f ffffffff rst_claim
N 00000000 00000000 0 00000000 rst_has_req
N 00000001 00000000 0 00000000 rst_bus_err
W 00001004 a5c3beef 5 00000000 en_lanes_0_2
R 00001004 00000000 f 000000ef en_after_lanes_0_2
W 00001004 77771234 2 00000000 en_lane_1
R 00001004 00000000 f 000012ef en_after_lane_1
R 00001005 00000000 f 00000012 en_byte_off_1
R 00001006 00000000 f 00000000 en_byte_off_2
W 00001004 00000208 f 00000000 en_lines_3_9
R 00001004 00000000 f 00000208 en_readback
I 00000000 00000228 0 00000000 raise_3_5_9
N 00000000 00000000 0 00000001 pend_has_req
R 00001000 00000000 f 00000208 pend_3_9
R 00001008 00000000 f 00000009 claim_9
N 00000000 00000000 0 00000001 has_req_after_9
R 00001008 00000000 f 00000003 claim_3
N 00000000 00000000 0 00000000 has_req_after_3
R 00001008 00000000 f ffffffff claim_empty
R 00001000 00000000 f 00000000 pend_empty
W 00001000 0000ffff f 00000000 pend_write_ignored
R 00001000 00000000 f 00000000 pend_still_empty
W 00001004 00008000 f 00000000 en_line_15
W 00002004 00000005 f 00000000 tmr_compare
R 00002004 00000000 f 00000005 tmr_compare_rb
W 00002000 00000001 f 00000000 tmr_enable
R 00002000 00000000 f 00000001 tmr_ctrl_rb
H 00000000 00000005 0 00000001 tmr_has_req
R 00001008 00000000 f 0000000f claim_15
W 00002000 00000000 f 00000000 tmr_disable
R 00003000 00000000 f 00000000 unmapped_rd
R 00002000 00000000 f 00000000 mapped_after_unmapped
W 00004000 12345678 f 00000000 unmapped_wr
R 00001004 00000000 f 00008000 mapped_after_unm_wr
N 00000001 00000000 0 00000000 bus_err_idle

// File: dv/tb_clock.sv
module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// File: hw/bus_fabric.sv
module bus_fabric #(
	parameter logic [31:0] IRQ_BASE   = 32'h0000_1000,
	parameter logic [31:0] TIMER_BASE = 32'h0000_2000
) (
	input  logic              clk,
	input  logic              rst,
	input  irq_pkg::bus_req_t bus_in,
	output irq_pkg::bus_req_t irq_req,
	input  irq_pkg::bus_rsp_t irq_rsp,
	output irq_pkg::bus_req_t tmr_req,
	input  irq_pkg::bus_rsp_t tmr_rsp,
	output irq_pkg::bus_rsp_t bus_out,
	output logic              bus_err
);

	localparam int HI = 31;
	localparam int LO = irq_pkg::REGION_BITS;

	logic sel_irq;
	logic sel_tmr;
	logic unmapped;
	logic unm_rd;
	logic unm_wr;
	logic unm_fc;
	logic unm_done;

	// Region match on the bits above the slave window
	assign sel_irq  = (bus_in.addr[HI:LO] == IRQ_BASE[HI:LO]);
	assign sel_tmr  = (bus_in.addr[HI:LO] == TIMER_BASE[HI:LO]);
	assign unmapped = !sel_irq && !sel_tmr;

	always_comb begin
		irq_req    = bus_in;
		irq_req.rd = bus_in.rd && sel_irq;
		irq_req.wr = bus_in.wr && sel_irq;
		tmr_req    = bus_in;
		tmr_req.rd = bus_in.rd && sel_tmr;
		tmr_req.wr = bus_in.wr && sel_tmr;
	end

	// Unmapped accesses complete like a slave would
	assign unm_rd = unmapped && bus_in.rd && !bus_in.wr;
	assign unm_wr = unmapped && bus_in.wr && !bus_in.rd;
	assign unm_fc = unm_rd || (unm_wr && unm_done);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			unm_done <= 1'b0;
		else
			unm_done <= unm_wr;
	end

	always_comb begin
		if (sel_irq)
			bus_out = irq_rsp;
		else if (sel_tmr)
			bus_out = tmr_rsp;
		else begin
			bus_out.rdata = '0;
			bus_out.fc    = unm_fc;
		end
	end

	assign bus_err = unm_fc;

	assert property (@(posedge clk) disable iff (rst)
		!(bus_in.rd && bus_in.wr));

endmodule

// File: hw/bus_slave_helper.svh
// Included inside each slave body, expects a bus_req_t named req

// Register word and byte lane within the slave region
wire [1:0] word_idx = req.addr[3:2];
wire [1:0] byte_off = req.addr[1:0];

// Only the first four words of the region are decoded
wire in_range = (req.addr[irq_pkg::REGION_BITS-1:4] == '0);

// Exactly one strobe makes a valid request
wire req_valid = req.rd ^ req.wr;

// Replace the byte lanes picked by mask
function automatic logic [31:0] merge_word(
	input logic [31:0] old_word,
	input logic [31:0] new_word,
	input logic [3:0]  lane_mask
);
	logic [31:0] merged;
	merged = old_word;
	for (int i = 0; i < 4; i++) begin
		if (lane_mask[i])
			merged[8*i +: 8] = new_word[8*i +: 8];
	end
	return merged;
endfunction

// File: hw/event_timer.sv
module event_timer #(
	parameter int COUNT_WIDTH = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  irq_pkg::bus_req_t req,
	output irq_pkg::bus_rsp_t rsp,
	output logic              irq
);

	`include "bus_slave_helper.svh"

	logic                   ctrl_en;
	logic [COUNT_WIDTH-1:0] compare;
	logic [COUNT_WIDTH-1:0] count;
	logic                   addr_hit;
	logic                   read_req;
	logic                   write_req;
	logic                   write_done;
	logic [31:0]            reg_word;
	logic [31:0]            old_word;
	logic [31:0]            new_word;
	irq_pkg::timer_reg_e    reg_sel;

	assign reg_sel = irq_pkg::timer_reg_e'(word_idx);

	always_comb begin
		addr_hit = in_range;
		reg_word = '0;
		case (reg_sel)
			irq_pkg::TMR_CTRL:    reg_word[irq_pkg::TMR_CTRL_EN_BIT] = ctrl_en;
			irq_pkg::TMR_COMPARE: reg_word = 32'(compare);
			irq_pkg::TMR_COUNT:   reg_word = 32'(count);
			default:              addr_hit = 1'b0;
		endcase
	end

	assign read_req  = addr_hit && req_valid && req.rd;
	assign write_req = addr_hit && req_valid && req.wr;

	// Count is read only so only the two control words merge
	assign old_word = (reg_sel == irq_pkg::TMR_COMPARE) ? 32'(compare) :
		32'(ctrl_en);
	assign new_word = merge_word(old_word, req.wdata, req.mask);

	assign rsp.rdata = read_req ? (reg_word >> (8 * byte_off)) : '0;
	assign rsp.fc    = read_req || (write_req && write_done);

	// One cycle pulse, count wraps on the same edge
	assign irq = ctrl_en && (count == compare);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl_en    <= 1'b0;
			compare    <= '0;
			count      <= '0;
			write_done <= 1'b0;
		end else if (write_req && !write_done) begin
			write_done <= 1'b1;
			if (reg_sel == irq_pkg::TMR_CTRL) begin
				ctrl_en <= new_word[irq_pkg::TMR_CTRL_EN_BIT];
				count   <= '0;
			end else if (reg_sel == irq_pkg::TMR_COMPARE) begin
				compare <= new_word[COUNT_WIDTH-1:0];
				count   <= '0;
			end
		end else begin
			if (!write_req)
				write_done <= 1'b0;
			if (ctrl_en)
				count <= (count == compare) ? '0 : count + 1'b1;
		end
	end

	// Holds across compare rewrites because a write restarts the count
	assert property (@(posedge clk) disable iff (rst)
		ctrl_en |-> count <= compare);

endmodule

// File: hw/interrupt_manager.sv
module interrupt_manager (
	input  logic                       clk,
	input  logic                       rst,
	input  irq_pkg::bus_req_t          req,
	output irq_pkg::bus_rsp_t          rsp,
	input  logic [irq_pkg::N_IRQ-1:0] intr_reqs,
	output logic                       has_req
);

	`include "bus_slave_helper.svh"

	logic [irq_pkg::N_IRQ-1:0] pending;
	logic [irq_pkg::N_IRQ-1:0] enable;
	logic [irq_pkg::N_IRQ-1:0] claimable;
	logic [irq_pkg::N_IRQ-1:0] claim_clr;
	logic [irq_pkg::CLAIM_BITS-1:0] claim_code;
	logic        has_claim;
	logic        addr_hit;
	logic        read_req;
	logic        write_req;
	logic        write_done;
	logic [31:0] reg_word;
	logic [31:0] enable_merged;
	irq_pkg::intr_reg_e reg_sel;

	assign reg_sel = irq_pkg::intr_reg_e'(word_idx);

	// Highest numbered line that is pending and enabled wins the claim
	assign claimable = pending & enable;
	assign has_claim = |claimable;

	always_comb begin
		claim_code = '0;
		for (int i = 0; i < irq_pkg::N_IRQ; i++) begin
			if (claimable[i])
				claim_code = irq_pkg::CLAIM_BITS'(i);
		end
	end

	always_comb begin
		addr_hit = 1'b0;
		reg_word = '0;
		case (reg_sel)
			irq_pkg::INTR_PENDING: begin
				addr_hit = in_range;
				reg_word = 32'(pending);
			end
			irq_pkg::INTR_ENABLE: begin
				addr_hit = in_range;
				reg_word = 32'(enable);
			end
			irq_pkg::INTR_CLAIM: begin
				addr_hit = in_range;
				reg_word = has_claim ? 32'(claim_code) : irq_pkg::NO_CLAIM;
			end
			default: begin
				addr_hit = 1'b0;
			end
		endcase
	end

	assign read_req  = addr_hit && req_valid && req.rd;
	assign write_req = addr_hit && req_valid && req.wr;

	// Claim read drops the claimed bit at the edge
	assign claim_clr = (read_req && reg_sel == irq_pkg::INTR_CLAIM && has_claim) ?
		(irq_pkg::N_IRQ'(1) << claim_code) : '0;

	assign enable_merged = merge_word(32'(enable), req.wdata, req.mask);

	assign rsp.rdata = read_req ? (reg_word >> (8 * byte_off)) : '0;
	assign rsp.fc    = read_req || (write_req && write_done);

	assign has_req = |pending;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending    <= '0;
			enable     <= '0;
			write_done <= 1'b0;
		end else begin
			pending <= (pending | (intr_reqs & enable)) & ~claim_clr;
			if (write_req && !write_done) begin
				write_done <= 1'b1;
				// Pending and claim ignore writes
				if (reg_sel == irq_pkg::INTR_ENABLE)
					enable <= enable_merged[irq_pkg::N_IRQ-1:0];
			end else if (!write_req) begin
				write_done <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		$rose(rsp.fc) |-> addr_hit && req_valid);

	assert property (@(posedge clk) disable iff (rst)
		(claim_clr & ~pending) == '0);

endmodule

// File: hw/irq_pkg.sv
package irq_pkg;

	// Interrupt request lines handled by the manager
	localparam int N_IRQ = 16;
	localparam int CLAIM_BITS = $clog2(N_IRQ);

	// Claim register value when nothing is pending and enabled
	localparam logic [31:0] NO_CLAIM = 32'hffff_ffff;

	// Each slave decodes the low REGION_BITS of the address
	localparam int REGION_BITS = 8;

	// Request from the master, one strobe at a time
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  mask;
		logic        rd;
		logic        wr;
	} bus_req_t;

	// Slave answer, fc marks function complete
	typedef struct packed {
		logic [31:0] rdata;
		logic        fc;
	} bus_rsp_t;

	// Word indices inside the interrupt manager region
	typedef enum logic [1:0] {
		INTR_PENDING = 2'd0,
		INTR_ENABLE  = 2'd1,
		INTR_CLAIM   = 2'd2
	} intr_reg_e;

	// Word indices inside the timer region
	typedef enum logic [1:0] {
		TMR_CTRL    = 2'd0,
		TMR_COMPARE = 2'd1,
		TMR_COUNT   = 2'd2
	} timer_reg_e;

	// Bit 0 of the timer control word
	localparam int TMR_CTRL_EN_BIT = 0;

endpackage

// File: hw/irq_subsystem.sv
module irq_subsystem #(
	parameter logic [31:0] IRQ_BASE    = 32'h0000_1000,
	parameter logic [31:0] TIMER_BASE  = 32'h0000_2000,
	parameter int          COUNT_WIDTH = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  irq_pkg::bus_req_t bus_in,
	output irq_pkg::bus_rsp_t bus_out,
	input  logic [14:0]       ext_irq,
	output logic              has_req,
	output logic              bus_err
);

	irq_pkg::bus_req_t irq_req;
	irq_pkg::bus_rsp_t irq_rsp;
	irq_pkg::bus_req_t tmr_req;
	irq_pkg::bus_rsp_t tmr_rsp;
	logic              tmr_irq;

	bus_fabric #(
		.IRQ_BASE  (IRQ_BASE),
		.TIMER_BASE(TIMER_BASE)
	) u_fabric (
		.clk    (clk),
		.rst    (rst),
		.bus_in (bus_in),
		.irq_req(irq_req),
		.irq_rsp(irq_rsp),
		.tmr_req(tmr_req),
		.tmr_rsp(tmr_rsp),
		.bus_out(bus_out),
		.bus_err(bus_err)
	);

	// Timer owns the top request line
	interrupt_manager u_intr (
		.clk      (clk),
		.rst      (rst),
		.req      (irq_req),
		.rsp      (irq_rsp),
		.intr_reqs({tmr_irq, ext_irq}),
		.has_req  (has_req)
	);

	event_timer #(
		.COUNT_WIDTH(COUNT_WIDTH)
	) u_timer (
		.clk(clk),
		.rst(rst),
		.req(tmr_req),
		.rsp(tmr_rsp),
		.irq(tmr_irq)
	);

endmodule

// File: irq_bus.f
+incdir+hw
hw/irq_pkg.sv
hw/bus_fabric.sv
hw/interrupt_manager.sv
hw/event_timer.sv
hw/irq_subsystem.sv
dv/tb_clock.sv
dv/irq_subsystem_tb.sv
